/* radiant.f */
verilog/radiant_bus_pkg.sv
verilog/radiant_board_pkg.sv
verilog/input_conditioner.sv
verilog/wb_intercon.sv
verilog/id_ctrl_regs.sv
verilog/trig_monitor.sv
verilog/cal_pulser.sv
verilog/radiant_top.sv
verification/radiant_clkgen.sv
verification/radiant_asserts.sv
verification/radiant_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the radiant testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module radiant_tb -f radiant.f -o radiant_sim

out="$(./obj_dir/radiant_sim)"
echo "$out"

if echo "$out" | grep -q "TB PASSED"; then
    exit 0
fi
exit 1

/* verification/radiant_asserts.sv */
`timescale 1ns/1ps

module radiant_asserts (
    input logic                     sysclk,
    input logic                     rst_n_i,
    input radiant_bus_pkg::wb_req_t req_i,
    input radiant_bus_pkg::wb_rsp_t rsp_i
);
    // never both terminations at once
    ack_err_excl: assert property (@(posedge sysclk) disable iff (!rst_n_i)
        !(rsp_i.ack && rsp_i.err))
        else $error("ack and err high in the same cycle");

    // single-cycle terminations
    ack_one_cycle: assert property (@(posedge sysclk) disable iff (!rst_n_i)
        rsp_i.ack |=> !rsp_i.ack)
        else $error("ack held for more than one cycle");
    err_one_cycle: assert property (@(posedge sysclk) disable iff (!rst_n_i)
        rsp_i.err |=> !rsp_i.err)
        else $error("err held for more than one cycle");

    // a response only after the edge that sampled a strobe
    ack_after_stb: assert property (@(posedge sysclk) disable iff (!rst_n_i)
        (rsp_i.ack || rsp_i.err) |-> $past(req_i.cyc && req_i.stb))
        else $error("response without a preceding strobe");

endmodule

/* verification/radiant_clkgen.sv */
`timescale 1ns/1ps

module radiant_clkgen (
    output logic sysclk,
    output logic rst_n_o
);
    // 20 ns period
    initial begin
        sysclk = 1'b0;
        forever begin
            #10 sysclk = ~sysclk;
        end
    end

    // low over the first two rising edges, released on a falling edge
    initial begin
        rst_n_o = 1'b0;
        repeat (2) @(posedge sysclk);
        @(negedge sysclk);
        rst_n_o = 1'b1;
    end

endmodule

/* verification/radiant_tb.sv */
`timescale 1ns/1ps

module radiant_tb;
    import radiant_bus_pkg::*;
    import radiant_board_pkg::*;

    logic        sysclk;
    logic        rst_n;
    wb_req_t     wb_req;
    wb_rsp_t     wb_rsp;
    trig_t       trig_raw;
    mt_t         mt_raw;
    logic        pulse;
    int          errors;
    int          tests;
    logic [31:0] lfsr_state;

    radiant_clkgen u_clkgen (.sysclk(sysclk), .rst_n_o(rst_n));

    radiant_top u_radiant_top (
        .sysclk   (sysclk),
        .rst_n_i  (rst_n),
        .wb_req_i (wb_req),
        .wb_rsp_o (wb_rsp),
        .trig_i   (trig_raw),
        .mt_i     (mt_raw),
        .pulse_o  (pulse)
    );

    bind wb_intercon radiant_asserts u_wb_asserts (
        .sysclk (sysclk), .rst_n_i (rst_n_i), .req_i (m_req_i), .rsp_i (m_rsp_o)
    );

    // galois lfsr, x^32+x^22+x^2+x+1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // one lfsr step per bit taken
    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    function automatic logic [7:0] reg_addr(input logic [1:0] slot, input logic [1:0] off);
        return {slot, 4'b0000, off};
    endfunction

    task automatic report_mismatch(input string what, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("error: t=%0t %s is %h, expected %h", $time, what, got, exp);
        errors++;
    endtask

    task automatic end_test(input string name, input int err_before);
        tests++;
        if (errors == err_before) begin
            $display("test %0d %s: ok", tests, name);
        end else begin
            $display("test %0d %s: %0d errors", tests, name, errors - err_before);
        end
    endtask

    // one classic cycle, called and returning 2 ns after a rising edge
    task automatic bus_access(input logic we, input logic [7:0] adr, input logic [31:0] wdat,
                              input logic expect_err, output logic [31:0] rdat);
        int waited;
        waited = 0;
        wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat};
        do begin
            @(posedge sysclk);
            #2;
            waited++;
        end while (!wb_rsp.ack && !wb_rsp.err && waited < 20);
        rdat = wb_rsp.dat;
        if (!wb_rsp.ack && !wb_rsp.err) begin
            $display("bus access to address %h got neither ack nor err in 20 cycles", adr);
            errors++;
        end else if (wb_rsp.err !== expect_err || wb_rsp.ack !== !expect_err) begin
            $display("error: t=%0t address %h answered ack %b err %b", $time, adr,
                     wb_rsp.ack, wb_rsp.err);
            errors++;
        end
        wb_req = '0;
    endtask

    // new raw levels on an idle bus, held while the conditioners settle
    task automatic hold_inputs(input trig_t t, input mt_t m);
        trig_raw = t;
        mt_raw   = m;
        repeat (8) @(posedge sysclk);
        #2;
    endtask

    // cycles up to the next pulse_o, -1 when none came within the limit
    task automatic wait_pulse(input int limit, output int cycles);
        cycles = 0;
        do begin
            @(posedge sysclk);
            #2;
            cycles++;
        end while (pulse !== 1'b1 && cycles < limit);
        if (pulse !== 1'b1) begin
            cycles = -1;
        end
    endtask

    task automatic run_tests();
        logic [31:0] rd;
        logic [31:0] r;
        logic [31:0] r2;
        logic [31:0] r3;
        logic [31:0] ctrl;
        trig_t       dis;
        trig_t       tog;
        trig_t       fired_exp;
        trig_t       rise;
        trig_t       clr;
        mt_t         mt_tog;
        mt_t         mt_exp;
        int          ev_exp;
        int          e0;
        int          period;
        int          gap;

        // 1: constant words
        e0 = errors;
        bus_access(1'b0, reg_addr(slot_id, reg_ident), '0, 1'b0, rd);
        if (rd !== ident_word) report_mismatch("ident", rd, ident_word);
        bus_access(1'b0, reg_addr(slot_id, reg_datever), '0, 1'b0, rd);
        if (rd !== datever_word) report_mismatch("date/version", rd, datever_word);
        end_test("ident and version", e0);

        // 2: fourth slot, random offset, read then write
        e0 = errors;
        take_bits(6, r);
        bus_access(1'b0, {2'b11, r[5:0]}, '0, 1'b1, rd);
        if (rd !== 32'd0) report_mismatch("unmapped read data", rd, 32'd0);
        bus_access(1'b1, {2'b11, r[5:0]}, r, 1'b1, rd);
        end_test("unmapped slot", e0);

        // 3: disable mask, then sparse random toggles against the model
        e0 = errors;
        take_bits(num_trig, r);
        dis = r[num_trig-1:0];
        bus_access(1'b1, reg_addr(slot_id, reg_chan_dis), 32'(dis), 1'b0, rd);
        bus_access(1'b0, reg_addr(slot_id, reg_chan_dis), '0, 1'b0, rd);
        if (rd !== 32'(dis)) report_mismatch("disable mask", rd, 32'(dis));
        // edges seen right after reset are flushed
        bus_access(1'b1, reg_addr(slot_trig, reg_fired), 32'hffff_ffff, 1'b0, rd);
        bus_access(1'b1, reg_addr(slot_trig, reg_evcount), '0, 1'b0, rd);
        fired_exp = '0;
        ev_exp = 0;
        for (int step = 0; step < 16; step++) begin
            take_bits(num_trig, r);
            take_bits(num_trig, r2);
            take_bits(num_trig, r3);
            tog  = r[num_trig-1:0] & r2[num_trig-1:0] & r3[num_trig-1:0];
            // polarity-corrected new level above corrected old level
            rise = ((trig_raw ^ tog) ^ trig_polarity) & ~(trig_raw ^ trig_polarity) & ~dis;
            fired_exp |= rise;
            if (rise != '0) ev_exp++;
            hold_inputs(trig_raw ^ tog, mt_raw);
        end
        bus_access(1'b0, reg_addr(slot_trig, reg_fired), '0, 1'b0, rd);
        if (rd !== 32'(fired_exp)) report_mismatch("fired flags", rd, 32'(fired_exp));
        take_bits(num_trig, r);
        clr = fired_exp & r[num_trig-1:0];
        bus_access(1'b1, reg_addr(slot_trig, reg_fired), 32'(clr), 1'b0, rd);
        fired_exp &= ~clr;
        bus_access(1'b0, reg_addr(slot_trig, reg_fired), '0, 1'b0, rd);
        if (rd !== 32'(fired_exp)) report_mismatch("fired after clear", rd, 32'(fired_exp));
        end_test("trigger fired flags", e0);

        // 4: event counter
        e0 = errors;
        bus_access(1'b0, reg_addr(slot_trig, reg_evcount), '0, 1'b0, rd);
        if (rd !== 32'(ev_exp)) report_mismatch("event count", rd, 32'(ev_exp));
        take_bits(32, r);
        bus_access(1'b1, reg_addr(slot_trig, reg_evcount), r, 1'b0, rd);
        bus_access(1'b0, reg_addr(slot_trig, reg_evcount), '0, 1'b0, rd);
        if (rd !== 32'd0) report_mismatch("event count after clear", rd, 32'd0);
        end_test("event counter", e0);

        // 5: timing-monitor flags
        e0 = errors;
        bus_access(1'b1, reg_addr(slot_id, reg_mt_flags), 32'h3, 1'b0, rd);
        mt_exp = '0;
        for (int step = 0; step < 8; step++) begin
            take_bits(num_mt, r);
            mt_tog = r[num_mt-1:0];
            mt_exp |= ((mt_raw ^ mt_tog) ^ mt_polarity) & ~(mt_raw ^ mt_polarity);
            hold_inputs(trig_raw, mt_raw ^ mt_tog);
        end
        bus_access(1'b0, reg_addr(slot_id, reg_mt_flags), '0, 1'b0, rd);
        if (rd !== 32'(mt_exp)) report_mismatch("monitor flags", rd, 32'(mt_exp));
        bus_access(1'b1, reg_addr(slot_id, reg_mt_flags), 32'h3, 1'b0, rd);
        bus_access(1'b0, reg_addr(slot_id, reg_mt_flags), '0, 1'b0, rd);
        if (rd !== 32'd0) report_mismatch("monitor flags after clear", rd, 32'd0);
        end_test("timing-monitor flags", e0);

        // 6: pulser period and stop
        e0 = errors;
        take_bits(pulse_sel_w, r);
        period = 1 << (int'(r[pulse_sel_w-1:0]) + 1);
        ctrl = 32'({r[pulse_sel_w-1:0], 1'b1});
        bus_access(1'b1, reg_addr(slot_pulse, reg_pulse_ctrl), ctrl, 1'b0, rd);
        bus_access(1'b0, reg_addr(slot_pulse, reg_pulse_ctrl), '0, 1'b0, rd);
        if (rd !== ctrl) report_mismatch("pulser control", rd, ctrl);
        wait_pulse(2 * period + 4, gap);
        if (gap < 0) begin
            $display("pulse_o never pulsed after the pulser was enabled");
            errors++;
        end
        for (int k = 0; k < 3; k++) begin
            wait_pulse(2 * period + 4, gap);
            if (gap != period) report_mismatch("pulse spacing", 32'(gap), 32'(period));
        end
        bus_access(1'b1, reg_addr(slot_pulse, reg_pulse_ctrl), ctrl & ~32'h1, 1'b0, rd);
        wait_pulse(64, gap);
        if (gap >= 0) begin
            $display("pulse_o still pulsed after the pulser was disabled");
            errors++;
        end
        end_test("calibration pulser", e0);
    endtask

    initial begin
        int waited;
        errors     = 0;
        tests      = 0;
        lfsr_state = 32'hf673;
        wb_req     = '0;
        trig_raw   = '0;
        mt_raw     = '0;
        waited     = 0;
        do begin
            @(posedge sysclk);
            #2;
            waited++;
        end while (rst_n !== 1'b1 && waited < 10);
        if (rst_n !== 1'b1) begin
            $display("reset was not released within 10 cycles");
            errors++;
        end else begin
            run_tests();
        end
        $display("done: %0d tests run, %0d errors", tests, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

/* verilog/cal_pulser.sv */
`timescale 1ns/1ps

module cal_pulser (
    input  logic                     sysclk,
    input  logic                     rst_n_i,
    input  radiant_bus_pkg::wb_req_t wb_req_i,
    output radiant_bus_pkg::wb_rsp_t wb_rsp_o,
    output logic                     pulse_o
);
    import radiant_bus_pkg::*;
    import radiant_board_pkg::*;

    // counter wide enough for the largest sel index
    localparam int cnt_w = 1 << pulse_sel_w;

    logic                   access;
    logic                   ctrl_wr;
    logic                   ack_q;
    logic [wb_dat_w-1:0]    rd_dat_q;
    logic                   enable_q;
    logic [pulse_sel_w-1:0] sel_q;
    logic [cnt_w-1:0]       count_q;
    logic [1:0]             catch_q;
    logic                   pulse_q;

    assign access  = wb_req_i.cyc && wb_req_i.stb && !ack_q;
    assign ctrl_wr = access && wb_req_i.we && (wb_req_i.adr[1:0] == reg_pulse_ctrl);

    always_ff @(posedge sysclk) begin
        if (!rst_n_i) begin
            ack_q    <= 1'b0;
            enable_q <= 1'b0;
            sel_q    <= pulse_sel_default;
            count_q  <= '0;
            catch_q  <= '0;
            pulse_q  <= 1'b0;
        end else begin
            ack_q <= access;
            // bit 0 enable, bits 3:1 period select
            if (ctrl_wr) begin
                enable_q <= wb_req_i.dat[0];
                sel_q    <= wb_req_i.dat[pulse_sel_w:1];
            end
            count_q <= count_q + 1'b1;
            // bit sel toggles every 2^sel cycles, rises every 2^(sel+1)
            catch_q <= {catch_q[0], count_q[sel_q]};
            pulse_q <= enable_q && catch_q[0] && !catch_q[1];
        end
    end

    // control readback, other offsets alias the same register
    always_ff @(posedge sysclk) begin
        if (access) begin
            rd_dat_q <= wb_dat_w'({sel_q, enable_q});
        end
    end

    assign wb_rsp_o.ack = ack_q;
    assign wb_rsp_o.err = 1'b0;
    assign wb_rsp_o.dat = rd_dat_q;
    assign pulse_o      = pulse_q;

endmodule

/* verilog/id_ctrl_regs.sv */
`timescale 1ns/1ps

module id_ctrl_regs (
    input  logic                     sysclk,
    input  logic                     rst_n_i,
    input  radiant_bus_pkg::wb_req_t wb_req_i,
    output radiant_bus_pkg::wb_rsp_t wb_rsp_o,
    input  radiant_board_pkg::mt_t   mt_rise_i,
    output radiant_board_pkg::trig_t chan_dis_o
);
    import radiant_bus_pkg::*;
    import radiant_board_pkg::*;

    logic                access;
    logic                wr_en;
    logic [1:0]          offset;
    logic                ack_q;
    logic [wb_dat_w-1:0] rd_dat_q;
    trig_t               chan_dis_q;
    mt_t                 mt_flags_q;
    mt_t                 mt_clr;

    // new access: strobe seen while ack is still low
    assign access = wb_req_i.cyc && wb_req_i.stb && !ack_q;
    assign wr_en  = access && wb_req_i.we;
    assign offset = wb_req_i.adr[1:0];

    // write-one-to-clear mask for the monitor flags
    assign mt_clr = (wr_en && offset == reg_mt_flags) ? wb_req_i.dat[num_mt-1:0] : '0;

    always_ff @(posedge sysclk) begin
        if (!rst_n_i) begin
            ack_q      <= 1'b0;
            chan_dis_q <= '0;
            mt_flags_q <= '0;
        end else begin
            ack_q <= access;
            if (wr_en && offset == reg_chan_dis) begin
                chan_dis_q <= wb_req_i.dat[num_trig-1:0];
            end
            // set after clear, so a same-cycle edge survives
            mt_flags_q <= (mt_flags_q & ~mt_clr) | mt_rise_i;
        end
    end

    // read data captured with the ack
    always_ff @(posedge sysclk) begin
        if (access) begin
            case (offset)
                reg_ident:    rd_dat_q <= ident_word;
                reg_datever:  rd_dat_q <= datever_word;
                reg_chan_dis: rd_dat_q <= wb_dat_w'(chan_dis_q);
                default:      rd_dat_q <= wb_dat_w'(mt_flags_q);
            endcase
        end
    end

    assign wb_rsp_o.ack = ack_q;
    assign wb_rsp_o.err = 1'b0;
    assign wb_rsp_o.dat = rd_dat_q;
    assign chan_dis_o   = chan_dis_q;

endmodule

/* verilog/input_conditioner.sv */
`timescale 1ns/1ps

module input_conditioner #(
    parameter type   data_t   = logic,
    parameter data_t polarity = '0
) (
    input  logic  sysclk,
    input  logic  rst_n_i,
    input  data_t raw_i,
    output data_t level_o,
    output data_t rise_o
);
    // sync stages and the previous level for edge detect
    data_t sync1_q;
    data_t sync2_q;
    data_t prev_q;
    data_t rise_q;

    always_ff @(posedge sysclk) begin
        if (!rst_n_i) begin
            sync1_q <= '0;
            sync2_q <= '0;
            prev_q  <= '0;
            rise_q  <= '0;
        end else begin
            // flip inverted pins first so every bit is active high
            sync1_q <= raw_i ^ polarity;
            sync2_q <= sync1_q;
            prev_q  <= sync2_q;
            // one-cycle pulse per bit, third edge after the input moves
            rise_q  <= sync2_q & ~prev_q;
        end
    end

    assign level_o = sync2_q;
    assign rise_o  = rise_q;

endmodule

/* verilog/radiant_board_pkg.sv */
package radiant_board_pkg;

    // channel counts
    localparam int num_trig = 24;
    localparam int num_mt   = 2;

    // one bit per trigger channel / timing-monitor input
    typedef logic [num_trig-1:0] trig_t;
    typedef logic [num_mt-1:0]   mt_t;

    // trigger inputs that land on a P pin are inverted on the board
    // a 1 here flips the raw level so that a trigger reads as a rise
    localparam trig_t trig_polarity = 24'b011011001001001010010110;
    // both timing-monitor pairs are swapped
    localparam mt_t mt_polarity = 2'b11;

    // ident word, ascii
    localparam logic [31:0] ident_word = "RDNT";

    // firmware version fields
    localparam logic [3:0]  ver_major = 4'd0;
    localparam logic [3:0]  ver_minor = 4'd2;
    localparam logic [7:0]  ver_rev   = 8'd11;
    // build date, day/month/year packed, zero when not stamped
    localparam logic [15:0] fw_date   = 16'd0;

    // date in the upper half, version in the lower half
    localparam logic [31:0] datever_word = {fw_date, ver_major, ver_minor, ver_rev};

    // pulser period select, period = 2^(sel+1) cycles
    localparam int pulse_sel_w = 3;
    // sel 3 gives one pulse every 16 cycles
    localparam logic [pulse_sel_w-1:0] pulse_sel_default = 3'd3;

endpackage

/* verilog/radiant_bus_pkg.sv */
package radiant_bus_pkg;

    // word address and data widths of the host port
    localparam int wb_adr_w = 8;
    localparam int wb_dat_w = 32;

    // master to slave, classic cycle with full-word access only
    typedef struct packed {
        logic                cyc;
        logic                stb;
        logic                we;
        logic [wb_adr_w-1:0] adr;
        logic [wb_dat_w-1:0] dat;
    } wb_req_t;

    // slave to master
    typedef struct packed {
        logic                ack;
        logic                err;
        logic [wb_dat_w-1:0] dat;
    } wb_rsp_t;

    // slot select, top two address bits (slot 3 left unmapped)
    localparam logic [1:0] slot_id    = 2'd0;
    localparam logic [1:0] slot_trig  = 2'd1;
    localparam logic [1:0] slot_pulse = 2'd2;

    // id block offsets
    localparam logic [1:0] reg_ident    = 2'd0;
    localparam logic [1:0] reg_datever  = 2'd1;
    localparam logic [1:0] reg_chan_dis = 2'd2;
    localparam logic [1:0] reg_mt_flags = 2'd3;
    // trigger monitor offsets
    localparam logic [1:0] reg_fired   = 2'd0;
    localparam logic [1:0] reg_evcount = 2'd1;
    // pulser offset
    localparam logic [1:0] reg_pulse_ctrl = 2'd0;

endpackage

/* verilog/radiant_top.sv */
`timescale 1ns/1ps

module radiant_top (
    input  logic                     sysclk,
    input  logic                     rst_n_i,
    input  radiant_bus_pkg::wb_req_t wb_req_i,
    output radiant_bus_pkg::wb_rsp_t wb_rsp_o,
    input  radiant_board_pkg::trig_t trig_i,
    input  radiant_board_pkg::mt_t   mt_i,
    output logic                     pulse_o
);
    import radiant_bus_pkg::*;
    import radiant_board_pkg::*;

    // per-slave bus legs
    wb_req_t id_req;
    wb_rsp_t id_rsp;
    wb_req_t trig_req;
    wb_rsp_t trig_rsp;
    wb_req_t pulse_req;
    wb_rsp_t pulse_rsp;

    // rising-edge pulses from the conditioners
    trig_t trig_rise;
    mt_t   mt_rise;

    // disable mask from id block to trigger monitor
    trig_t chan_dis;

    wb_intercon u_intercon (
        .sysclk      (sysclk),
        .rst_n_i     (rst_n_i),
        .m_req_i     (wb_req_i),
        .m_rsp_o     (wb_rsp_o),
        .id_req_o    (id_req),
        .trig_req_o  (trig_req),
        .pulse_req_o (pulse_req),
        .id_rsp_i    (id_rsp),
        .trig_rsp_i  (trig_rsp),
        .pulse_rsp_i (pulse_rsp)
    );

    // trigger inputs, polarity fixed per channel
    // only the edges are used here, level left open
    input_conditioner #(.data_t(trig_t), .polarity(trig_polarity)) u_trig_cond (
        .sysclk  (sysclk),
        .rst_n_i (rst_n_i),
        .raw_i   (trig_i),
        .level_o (),
        .rise_o  (trig_rise)
    );

    // timing-monitor inputs, same path as the triggers
    input_conditioner #(.data_t(mt_t), .polarity(mt_polarity)) u_mt_cond (
        .sysclk  (sysclk),
        .rst_n_i (rst_n_i),
        .raw_i   (mt_i),
        .level_o (),
        .rise_o  (mt_rise)
    );

    id_ctrl_regs u_id (
        .sysclk     (sysclk),
        .rst_n_i    (rst_n_i),
        .wb_req_i   (id_req),
        .wb_rsp_o   (id_rsp),
        .mt_rise_i  (mt_rise),
        .chan_dis_o (chan_dis)
    );

    trig_monitor u_trig (
        .sysclk      (sysclk),
        .rst_n_i     (rst_n_i),
        .wb_req_i    (trig_req),
        .wb_rsp_o    (trig_rsp),
        .trig_rise_i (trig_rise),
        .chan_dis_i  (chan_dis)
    );

    cal_pulser u_pulser (
        .sysclk   (sysclk),
        .rst_n_i  (rst_n_i),
        .wb_req_i (pulse_req),
        .wb_rsp_o (pulse_rsp),
        .pulse_o  (pulse_o)
    );

endmodule

/* verilog/trig_monitor.sv */
`timescale 1ns/1ps

module trig_monitor (
    input  logic                     sysclk,
    input  logic                     rst_n_i,
    input  radiant_bus_pkg::wb_req_t wb_req_i,
    output radiant_bus_pkg::wb_rsp_t wb_rsp_o,
    input  radiant_board_pkg::trig_t trig_rise_i,
    input  radiant_board_pkg::trig_t chan_dis_i
);
    import radiant_bus_pkg::*;
    import radiant_board_pkg::*;

    logic                access;
    logic                wr_en;
    logic [1:0]          offset;
    logic                ack_q;
    logic [wb_dat_w-1:0] rd_dat_q;
    trig_t               hit;
    trig_t               fired_q;
    trig_t               fired_clr;
    logic                ev_clr;
    logic [31:0]         evcount_q;

    assign access = wb_req_i.cyc && wb_req_i.stb && !ack_q;
    assign wr_en  = access && wb_req_i.we;
    assign offset = wb_req_i.adr[1:0];

    // rises on channels that are not masked off
    assign hit = trig_rise_i & ~chan_dis_i;

    assign fired_clr = (wr_en && offset == reg_fired) ? wb_req_i.dat[num_trig-1:0] : '0;
    // any write to the counter clears it, data ignored
    assign ev_clr    = wr_en && (offset == reg_evcount);

    always_ff @(posedge sysclk) begin
        if (!rst_n_i) begin
            ack_q     <= 1'b0;
            fired_q   <= '0;
            evcount_q <= '0;
        end else begin
            ack_q   <= access;
            // new rises win over a same-cycle clear
            fired_q <= (fired_q & ~fired_clr) | hit;
            // one count per cycle with any enabled rise
            if (ev_clr) begin
                evcount_q <= 32'(|hit);
            end else if (|hit) begin
                evcount_q <= evcount_q + 32'd1;
            end
        end
    end

    always_ff @(posedge sysclk) begin
        if (access) begin
            case (offset)
                reg_fired:   rd_dat_q <= wb_dat_w'(fired_q);
                reg_evcount: rd_dat_q <= evcount_q;
                // unused offsets read as zero
                default:     rd_dat_q <= '0;
            endcase
        end
    end

    assign wb_rsp_o.ack = ack_q;
    assign wb_rsp_o.err = 1'b0;
    assign wb_rsp_o.dat = rd_dat_q;

endmodule

/* verilog/wb_intercon.sv */
`timescale 1ns/1ps

module wb_intercon (
    input  logic                     sysclk,
    input  logic                     rst_n_i,
    input  radiant_bus_pkg::wb_req_t m_req_i,
    output radiant_bus_pkg::wb_rsp_t m_rsp_o,
    output radiant_bus_pkg::wb_req_t id_req_o,
    output radiant_bus_pkg::wb_req_t trig_req_o,
    output radiant_bus_pkg::wb_req_t pulse_req_o,
    input  radiant_bus_pkg::wb_rsp_t id_rsp_i,
    input  radiant_bus_pkg::wb_rsp_t trig_rsp_i,
    input  radiant_bus_pkg::wb_rsp_t pulse_rsp_i
);
    import radiant_bus_pkg::*;

    logic [1:0] slot;
    logic       unmapped;
    logic       err_q;

    // slot from the top two word-address bits
    assign slot     = m_req_i.adr[wb_adr_w-1 -: 2];
    assign unmapped = (slot != slot_id) && (slot != slot_trig) && (slot != slot_pulse);

    // every slave sees the full request, stb only on a slot match
    always_comb begin
        id_req_o        = m_req_i;
        trig_req_o      = m_req_i;
        pulse_req_o     = m_req_i;
        id_req_o.stb    = m_req_i.stb && (slot == slot_id);
        trig_req_o.stb  = m_req_i.stb && (slot == slot_trig);
        pulse_req_o.stb = m_req_i.stb && (slot == slot_pulse);
    end

    // error for the empty slot, one cycle, same timing as a slave ack
    always_ff @(posedge sysclk) begin
        if (!rst_n_i) begin
            err_q <= 1'b0;
        end else begin
            err_q <= m_req_i.cyc && m_req_i.stb && unmapped && !err_q;
        end
    end

    // response back to the master, address held until ack so mux is stable
    always_comb begin
        case (slot)
            slot_id:    m_rsp_o = id_rsp_i;
            slot_trig:  m_rsp_o = trig_rsp_i;
            slot_pulse: m_rsp_o = pulse_rsp_i;
            default: begin
                m_rsp_o     = '0;
                m_rsp_o.err = err_q;
            end
        endcase
    end

endmodule
